// ==== Bender.yml ====
package:
  name: rtc_time

export_include_dirs:
  - common

sources:
  - files:
      - common/rtc_pkg.sv
      - common/i2c_cmd_if.sv
      - hw/i2c_master/i2c_master.sv
      - hw/rtc_reader.sv
      - hw/rtc_time_top.sv
  - target: test
    files:
      - tb/rtc_clock_model.sv
      - tb/rtc_time_checker.sv
      - tb/rtc_time_sva.sv
      - tb/rtc_time_tb.sv

// ==== common/i2c_cmd_if.sv ====
// I2C command interface

`timescale 1ns/1ps

interface i2c_cmd_if
  import rtc_pkg::*;
();

  // request side
  logic       wr_ctrl;  // one-cycle command strobe
  i2c_op_t    op;       // read or write
  logic [6:0] dev_addr; // 7-bit slave address
  logic [7:0] reg_addr; // register index inside the slave
  logic [7:0] wdata;    // payload for op_write

  // status side
  logic       busy;     // high while a transaction runs
  logic       ack_ok;   // all address and register bytes acked, valid on busy fall
  logic [7:0] rdata;    // byte read back, valid on busy fall

  modport requester (
    output wr_ctrl, op, dev_addr, reg_addr, wdata,
    input  busy, ack_ok, rdata
  );

  modport executor (
    input  wr_ctrl, op, dev_addr, reg_addr, wdata,
    output busy, ack_ok, rdata
  );

endinterface

// ==== common/rtc_cfg.svh ====
// RTC reader configuration

`ifndef RTC_CFG_SVH
`define RTC_CFG_SVH

// system clock in MHz
`define RTC_CLK_MHZ 25

// clocks per quarter of an scl period, about 100 kHz on the bus
`define RTC_SCL_DIV ((`RTC_CLK_MHZ * 10) / 4)

// one register request every 2^n + 1 clocks
`define RTC_SLOW_BITS 18

// 7-bit i2c address of the clock chip
`define RTC_DEV_ADDR 7'h6F

`endif

// ==== common/rtc_pkg.sv ====
// RTC reader shared types

package rtc_pkg;

  // i2c master sequencer states
  typedef enum logic [3:0] {
    st_idle,     // bus released, waiting for a command
    st_start,    // start condition
    st_addr_wr,  // device address + write bit, then ack
    st_reg_addr, // register address byte, then ack
    st_wdata,    // data byte for a register write
    st_rstart,   // repeated start before the read phase
    st_addr_rd,  // device address + read bit, then ack
    st_rdata,    // eight bits shifted in from the slave
    st_nack,     // master nack ends the single-byte read
    st_stop,     // stop condition
    st_done      // one cycle, busy already low
  } i2c_state_t;

  // command opcode, one bit on the interface
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } i2c_op_t;

  // mcp7940n timekeeping register map, 0..6
  typedef enum logic [2:0] {
    reg_sec   = 3'd0, // seconds + oscillator start bit
    reg_min   = 3'd1,
    reg_hour  = 3'd2, // hours + 12/24 select
    reg_wday  = 3'd3, // weekday + battery flags
    reg_day   = 3'd4,
    reg_month = 3'd5, // month + leap year flag
    reg_year  = 3'd6
  } rtc_reg_t;

endpackage

// ==== hw/i2c_master/i2c_master.sv ====
// Open-drain I2C master

`timescale 1ns/1ps

module i2c_master
  import rtc_pkg::*;
#(
  parameter int scl_div = 62 // clocks per quarter scl period
) (
  input  logic        clk,
  input  logic        reset,
  i2c_cmd_if.executor cmd,
  inout  wire         sda,
  inout  wire         scl
);

  localparam int cnt_w = $clog2(scl_div + 1);

  i2c_state_t       state;
  logic [cnt_w-1:0] qcnt;     // quarter period divider
  logic             qtick;    // last clock of a quarter
  logic [1:0]       phase;    // quarter within the current bit
  logic [3:0]       bit_cnt;  // bit within a byte, 8 is the ack slot
  logic [7:0]       sreg;     // tx/rx shift register
  logic             ack_err;  // some byte was not acked
  logic             sda_s;    // registered sda input
  logic             scl_low;  // registered line drivers
  logic             sda_low;
  logic             scl_low_d;
  logic             sda_low_d;
  logic             bit_end;  // end of quarter 3
  logic             sample;   // end of quarter 1, scl high
  logic             last_bit;
  logic             wr_byte;  // byte sent by the master, slave acks
  i2c_op_t          op_q;     // command latched at the strobe
  logic [6:0]       dev_q;
  logic [7:0]       reg_q;
  logic [7:0]       wdata_q;

  assign qtick   = (qcnt == cnt_w'(scl_div - 1));
  assign bit_end = qtick && (phase == 2'd3);
  assign sample  = qtick && (phase == 2'd1);
  assign wr_byte = state inside {st_addr_wr, st_reg_addr, st_wdata, st_addr_rd};
  assign last_bit = (state == st_rdata) ? (bit_cnt == 4'd7) : (bit_cnt == 4'd8);

  // open drain, only ever pull low
  assign sda = sda_low ? 1'b0 : 1'bz;
  assign scl = scl_low ? 1'b0 : 1'bz;

  // line levels per state and quarter
  // data bits: scl L H H L, sda only moves across the 3->0 boundary
  always_comb begin
    scl_low_d = 1'b0;
    sda_low_d = 1'b0;
    case (state)
      st_start: begin
        scl_low_d = (phase == 2'd3);
        sda_low_d = phase[1]; // sda falls with scl high
      end
      st_rstart: begin
        scl_low_d = (phase == 2'd0) || (phase == 2'd3);
        sda_low_d = phase[1];
      end
      st_addr_wr, st_reg_addr, st_wdata, st_addr_rd: begin
        scl_low_d = (phase == 2'd0) || (phase == 2'd3);
        sda_low_d = (bit_cnt != 4'd8) && !sreg[7]; // ack slot released
      end
      st_rdata, st_nack: begin
        scl_low_d = (phase == 2'd0) || (phase == 2'd3); // sda released, nack = high
      end
      st_stop: begin
        scl_low_d = (phase == 2'd0);
        sda_low_d = !phase[1]; // sda rises with scl high
      end
      default: ; // idle and done keep both lines released
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      scl_low <= 1'b0;
      sda_low <= 1'b0;
      sda_s   <= 1'b1;
    end else begin
      scl_low <= scl_low_d;
      sda_low <= sda_low_d;
      sda_s   <= sda;
    end
  end

  // sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      qcnt       <= '0;
      phase      <= 2'd0;
      bit_cnt    <= 4'd0;
      ack_err    <= 1'b0;
      cmd.busy   <= 1'b0;
      cmd.ack_ok <= 1'b0;
    end else begin
      case (state)
        st_idle, st_done: begin
          if (state == st_done)
            state <= st_idle;
          if (cmd.wr_ctrl) begin // accepted only when not busy
            state    <= st_start;
            cmd.busy <= 1'b1;
            ack_err  <= 1'b0;
            qcnt     <= '0;
            phase    <= 2'd0;
            bit_cnt  <= 4'd0;
            op_q     <= cmd.op;
            dev_q    <= cmd.dev_addr;
            reg_q    <= cmd.reg_addr;
            wdata_q  <= cmd.wdata;
          end
        end
        default: begin
          if (qtick) begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
          end else begin
            qcnt <= qcnt + 1'b1;
          end

          // scl is high here, data stable
          if (sample) begin
            if (state == st_rdata)
              sreg <= {sreg[6:0], sda_s};
            else if (wr_byte && bit_cnt == 4'd8 && sda_s)
              ack_err <= 1'b1; // slave left sda high
          end

          if (bit_end) begin
            case (state)
              st_start: begin
                state <= st_addr_wr;
                sreg  <= {dev_q, 1'b0};
              end
              st_rstart: begin
                state <= st_addr_rd;
                sreg  <= {dev_q, 1'b1};
              end
              st_nack: state <= st_stop;
              st_stop: begin
                state      <= st_done;
                cmd.busy   <= 1'b0;
                cmd.ack_ok <= !ack_err;
                cmd.rdata  <= sreg; // rx byte, shift stops after st_rdata
              end
              default: begin // byte states
                if (!last_bit) begin
                  bit_cnt <= bit_cnt + 4'd1;
                  if (wr_byte && bit_cnt < 4'd7)
                    sreg <= {sreg[6:0], 1'b0};
                  else if (wr_byte)
                    sreg <= 8'hff; // keep sda released through the ack slot
                end else begin
                  bit_cnt <= 4'd0;
                  case (state)
                    st_addr_wr: begin
                      state <= st_reg_addr;
                      sreg  <= reg_q;
                    end
                    st_reg_addr: begin
                      state <= (op_q == op_read) ? st_rstart : st_wdata;
                      sreg  <= wdata_q; // only used on the write path
                    end
                    st_wdata:   state <= st_stop;
                    st_addr_rd: state <= st_rdata;
                    default:    state <= st_nack; // st_rdata
                  endcase
                end
              end
            endcase
          end
        end
      endcase
    end
  end

endmodule

// ==== hw/rtc_reader.sv ====
// RTC register reader

`timescale 1ns/1ps

`include "rtc_cfg.svh"

module rtc_reader
  import rtc_pkg::*;
#(
  parameter int slow_bits = 18 // request every 2^n + 1 clocks
) (
  input  logic         clk,
  input  logic         reset,
  i2c_cmd_if.requester cmd,
  output logic         tick,     // one cycle, datetime refreshed
  output logic [55:0]  datetime  // bcd {yy, mm, dd, wd, hh, mm, ss}
);

  logic [slow_bits:0] slow;     // slowdown counter
  logic               req;      // request strobe
  rtc_reg_t           reg_idx;  // register to request next
  rtc_reg_t           prev_idx; // register of the running transaction
  logic               busy_q;
  logic               done_ok;  // transaction finished and acked
  logic [6:0][7:0]    regs;     // masked register copies, index = register

  // keep only the time bits of each register
  function automatic logic [7:0] mask_byte(input rtc_reg_t r, input logic [7:0] b);
    logic [7:0] m;
    case (r)
      reg_sec, reg_min, reg_day: m = 8'h7f; // st bit in seconds
      reg_hour:                  m = 8'h3f; // 12/24 select
      reg_wday:                  m = 8'h07; // oscrun, pwrfail, vbaten
      reg_month:                 m = 8'h1f; // leap year flag
      default:                   m = 8'hff; // year is plain bcd
    endcase
    return b & m;
  endfunction

  // strobe on the top bit, counter wraps right after it
  assign req = slow[slow_bits];

  always_ff @(posedge clk) begin
    if (reset)
      slow <= '0;
    else if (req)
      slow <= '0;
    else
      slow <= slow + 1'b1;
  end

  // walk 6 down to 0 and around again
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_idx  <= reg_year;
      prev_idx <= reg_sec;
    end else if (req) begin
      reg_idx  <= (reg_idx == reg_sec) ? reg_year : rtc_reg_t'(reg_idx - 3'd1);
      prev_idx <= reg_idx;
    end
  end

  // single register read of the chip
  assign cmd.wr_ctrl  = req;
  assign cmd.op       = op_read;
  assign cmd.dev_addr = `RTC_DEV_ADDR;
  assign cmd.reg_addr = {5'd0, reg_idx};
  assign cmd.wdata    = 8'h00; // unused for reads

  // busy falling edge, nacked transfers are dropped
  assign done_ok = busy_q && !cmd.busy && cmd.ack_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      tick   <= 1'b0;
      regs   <= '0;
    end else begin
      busy_q <= cmd.busy;
      tick   <= done_ok && (prev_idx == reg_sec); // seconds closes the round
      if (done_ok)
        regs[prev_idx] <= mask_byte(prev_idx, cmd.rdata);
    end
  end

  // year in the top byte, seconds in the bottom one
  assign datetime = regs;

endmodule

// ==== hw/rtc_time_top.sv ====
// RTC date and time reader top

`timescale 1ns/1ps

`include "rtc_cfg.svh"

module rtc_time_top #(
  parameter int slow_bits = `RTC_SLOW_BITS, // read slowdown exponent
  parameter int scl_div   = `RTC_SCL_DIV    // clocks per quarter scl period
) (
  input  logic        clk,
  input  logic        reset,
  inout  wire         sda,      // pulled up on the board
  inout  wire         scl,      // pulled up on the board
  output logic        tick,     // datetime just refreshed
  output logic [55:0] datetime  // bcd {yy, mm, dd, wd, hh, mm, ss}
);

  i2c_cmd_if cmd_bus ();

  // register scheduler and byte capture
  rtc_reader #(
    .slow_bits (slow_bits)
  ) i_rtc_reader (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd_bus),
    .tick     (tick),
    .datetime (datetime)
  );

  // bus side
  i2c_master #(
    .scl_div (scl_div)
  ) i_i2c_master (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd_bus),
    .sda   (sda),
    .scl   (scl)
  );

endmodule

// ==== rtc_time_top.f ====
+incdir+common
common/rtc_pkg.sv
common/i2c_cmd_if.sv
hw/i2c_master/i2c_master.sv
hw/rtc_reader.sv
hw/rtc_time_top.sv
tb/rtc_clock_model.sv
tb/rtc_time_checker.sv
tb/rtc_time_sva.sv
tb/rtc_time_tb.sv

// ==== tb/rtc_clock_model.sv ====
// Behavioral RTC chip model

`timescale 1ns/1ps

`include "rtc_cfg.svh"

module rtc_clock_model
  import rtc_pkg::*;
#(
  parameter int n_rec = 8
) (
  inout  wire          sda,
  inout  wire          scl,
  input  logic [115:0] trace [n_rec], // {raw yy..ss, nack flag, expected}
  output int           rec_idx        // rounds served or refused so far
);

  logic       sda_low;  // open drain pull down
  logic [7:0] rx;
  logic       ours;     // our address and a record is left
  logic       refuse;   // register 0 of a nack record
  rtc_reg_t   reg_ptr;

  assign sda = sda_low ? 1'b0 : 1'bz;

  // msb first, sampled on scl rising
  task automatic get_byte(output logic [7:0] b);
    b = 8'h00;
    repeat (8) begin
      @(posedge scl);
      b = {b[6:0], sda};
    end
  endtask

  task automatic put_ack(input logic ack);
    @(negedge scl);
    sda_low = ack; // pull low through the ack slot
    @(posedge scl);
    @(negedge scl);
    sda_low = 1'b0;
  endtask

  // called right after the ack slot, scl is low
  task automatic put_byte(input logic [7:0] b);
    int i;
    for (i = 7; i >= 0; i--) begin
      sda_low = !b[i];
      @(posedge scl);
      @(negedge scl);
    end
    sda_low = 1'b0; // line free for the master nack
  endtask

  initial begin
    sda_low = 1'b0;
    rec_idx = 0;
    forever begin
      @(negedge sda iff scl === 1'b1); // start
      get_byte(rx);
      ours = (rx[7:1] == `RTC_DEV_ADDR) && !rx[0] && (rec_idx < n_rec);
      put_ack(ours);
      get_byte(rx);                    // register pointer
      reg_ptr = rtc_reg_t'(rx[2:0]);
      refuse  = ours && (reg_ptr == reg_sec) && trace[rec_idx][56];
      put_ack(ours && !refuse);
      @(negedge sda iff scl === 1'b1); // repeated start
      get_byte(rx);                    // address + read bit
      put_ack(ours && !refuse);
      if (ours && !refuse)
        put_byte(trace[rec_idx][60 + 8 * reg_ptr +: 8]);
      @(posedge sda iff scl === 1'b1); // stop
      if (ours && reg_ptr == reg_sec)
        rec_idx++; // seconds closes the round
    end
  end

endmodule

// ==== tb/rtc_time_checker.sv ====
// Datetime checker

`timescale 1ns/1ps

module rtc_time_checker #(
  parameter int n_rec = 8
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         tick,
  input  logic [55:0]  datetime,
  input  logic [115:0] trace [n_rec],
  input  int           rec_idx,  // rounds finished on the bus
  output logic         done,
  output int           err_cnt,
  output int           ok_cnt
);

  localparam int tick_win = 24; // stop condition to tick is a handful of clocks

  int          tick_cnt;  // all ticks after reset
  int          good_cnt;  // records that must tick
  int          r;
  logic        seen;
  logic [55:0] got;       // datetime at the tick

  always @(negedge clk) begin
    if (reset)
      tick_cnt <= 0;
    else if (tick)
      tick_cnt <= tick_cnt + 1;
  end

  initial begin
    done     = 1'b0;
    err_cnt  = 0;
    ok_cnt   = 0;
    good_cnt = 0;
    @(negedge reset);
    for (r = 0; r < n_rec; r++) begin
      wait (rec_idx > r);
      seen = 1'b0;
      got  = '0;
      repeat (tick_win) begin
        @(negedge clk); // outputs settled mid cycle
        if (tick && !seen) begin
          seen = 1'b1;
          got  = datetime;
        end
      end
      if (trace[r][56]) begin
        if (seen) begin
          err_cnt++;
          $display("record %0d: tick seen although the round was nacked", r);
        end else
          $display("record %0d: nacked round, no tick", r);
      end else begin
        good_cnt++;
        if (!seen) begin
          err_cnt++;
          $display("record %0d: no tick after the round ended", r);
        end else if (got !== trace[r][55:0]) begin
          err_cnt++;
          $display("[ERROR] record %0d datetime expected %h actual %h",
                   r, trace[r][55:0], got);
        end else begin
          ok_cnt++;
          $display("record %0d: datetime %h ok", r, got);
        end
      end
    end
    // catches ticks in the middle of a round
    if (tick_cnt != good_cnt) begin
      err_cnt++;
      $display("saw %0d ticks but %0d records should tick", tick_cnt, good_cnt);
    end
    done = 1'b1;
  end

endmodule

// ==== tb/rtc_time_sva.sv ====
// Reader and I2C master assertions

`timescale 1ns/1ps

module rtc_time_sva
  import rtc_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       tick,
  input logic [7:0] sec_byte, // low byte of datetime
  input logic       wr_ctrl,
  input logic       busy,
  input i2c_state_t state,
  input logic       sda,
  input logic       scl
);

  int   fail_cnt = 0; // failures of this instance
  logic ticked;       // first full round done

  always_ff @(posedge clk) begin
    if (reset)
      ticked <= 1'b0;
    else if (tick)
      ticked <= 1'b1;
  end

  a_tick_pulse: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
    else begin
      fail_cnt++;
      $error("tick high for more than one cycle");
    end

  // seconds only land together with the tick
  a_quiet_start: assert property (@(posedge clk) disable iff (reset)
    !ticked && !tick |-> sec_byte == 8'h00)
    else begin
      fail_cnt++;
      $error("seconds byte set before the first tick");
    end

  // a strobe only reaches an idle master and always starts it
  a_busy_rise: assert property (@(posedge clk) disable iff (reset)
    wr_ctrl |-> !busy ##1 busy)
    else begin
      fail_cnt++;
      $error("command strobe while busy or not accepted");
    end

  // the transaction ends after the stop with both lines released
  a_busy_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> state == st_done && sda && scl)
    else begin
      fail_cnt++;
      $error("busy fell outside the done state or with the bus held low");
    end

  // sda moves under a high scl only for start, repeated start and stop
  a_sda_stable: assert property (@(posedge clk) disable iff (reset)
    $changed(sda) && scl && $past(scl) |-> state inside {st_start, st_rstart, st_stop})
    else begin
      fail_cnt++;
      $error("sda changed while scl was high");
    end

endmodule

bind rtc_reader rtc_time_sva i_reader_sva (
  .clk(clk), .reset(reset), .tick(tick), .sec_byte(datetime[7:0]),
  .wr_ctrl(1'b0), .busy(1'b0), .state(rtc_pkg::st_idle), .sda(1'b1), .scl(1'b1)
);

bind i2c_master rtc_time_sva i_master_sva (
  .clk(clk), .reset(reset), .tick(1'b0), .sec_byte(8'h00),
  .wr_ctrl(cmd.wr_ctrl), .busy(cmd.busy), .state(state), .sda(sda), .scl(scl)
);

// ==== tb/rtc_time_tb.sv ====
// RTC reader testbench

`timescale 1ns/1ps

module rtc_time_tb;

  localparam int n_rec     = 8;
  localparam int slow_bits = 10; // request every 1025 clocks
  localparam int scl_div   = 4;
  localparam int limit     = (n_rec + 2) * 7 * ((1 << slow_bits) + 1);

  logic         clk;
  logic         reset;
  wire          sda;
  wire          scl;
  logic         tick;
  logic [55:0]  datetime;
  logic [115:0] trace_mem [n_rec]; // {raw yy..ss, nack flag, expected}
  int           rec_idx;
  logic         done;
  int           err_cnt;
  int           ok_cnt;
  int           sva_cnt;
  int           cycles;

  pullup (sda); // board pull-ups
  pullup (scl);

  always #50 clk = ~clk;

  initial begin
    $readmemh("tb/rtc_time_trace.txt", trace_mem);
    clk   = 1'b0;
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0; // only input driven, on a falling edge
  end

  rtc_time_top #(
    .slow_bits (slow_bits),
    .scl_div   (scl_div)
  ) i_rtc_time_top (
    .clk      (clk),
    .reset    (reset),
    .sda      (sda),
    .scl      (scl),
    .tick     (tick),
    .datetime (datetime)
  );

  rtc_clock_model #(.n_rec(n_rec)) i_rtc_clock_model (
    .sda     (sda),
    .scl     (scl),
    .trace   (trace_mem),
    .rec_idx (rec_idx)
  );

  rtc_time_checker #(.n_rec(n_rec)) i_rtc_time_checker (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .datetime (datetime),
    .trace    (trace_mem),
    .rec_idx  (rec_idx),
    .done     (done),
    .err_cnt  (err_cnt),
    .ok_cnt   (ok_cnt)
  );

  // all records plus two spare rounds
  initial begin
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the checker never finished", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    wait (done === 1'b1);
    sva_cnt = i_rtc_time_top.i_rtc_reader.i_reader_sva.fail_cnt
            + i_rtc_time_top.i_i2c_master.i_master_sva.fail_cnt;
    $display("records %0d, datetime matches %0d, checker errors %0d, assertion failures %0d",
             n_rec, ok_cnt, err_cnt, sva_cnt);
    if (err_cnt == 0 && sva_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/rtc_time_trace.txt ====
// raw registers yy_mo_dd_wd_hh_mi_ss, nack flag, expected datetime yy_mo_dd_wd_hh_mi_ss
// nack flag 1 refuses the register 0 address byte, expected then unused
24_02_29_04_13_45_30_0_24_02_29_04_13_45_30
23_22_28_3d_52_87_d9_0_23_02_28_05_12_07_59
99_09_09_09_09_09_09_1_00_00_00_00_00_00_00
25_12_31_03_23_59_58_0_25_12_31_03_23_59_58
00_01_01_01_00_00_00_0_00_01_01_01_00_00_00
99_32_b1_3f_63_d9_d9_0_99_12_31_07_23_59_59
30_01_01_02_08_00_00_1_00_00_00_00_00_00_00
30_06_15_06_08_30_00_0_30_06_15_06_08_30_00
